/* ddr_axi_pkg.sv */
`default_nettype none

package ddr_axi_pkg;

  localparam int DATA_W     = 128;         // Native word and AXI beat width
  localparam int MASK_W     = DATA_W / 8;  // One mask bit per byte
  localparam int ADDR_W     = 32;          // Byte and word address width
  localparam int WORD_SHIFT = 4;           // Byte offset bits inside one word

  localparam logic [1:0] BURST_INCR = 2'b01;  // Address steps per beat

  // One accepted address command as held in the queues
  typedef struct packed {
    logic [ADDR_W-1:0] word_addr;  // Byte address with offset dropped
    logic [7:0]        len;        // Beats minus one
    logic [1:0]        burst;
    logic [7:0]        id;
  } axi_cmd_t;

  // One write on the native controller interface
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [MASK_W-1:0] mask;  // High bit masks the byte
  } native_wr_t;

endpackage

`default_nettype wire

/* ddr_axi_queue.sv */
`timescale 1ns/100ps
`default_nettype none

module ddr_axi_queue #(
  parameter int QUEUE_DEPTH = 32,
  parameter type entry_t = logic [7:0]
) (
  input  logic   axi_clk,
  input  logic   cal_done,
  input  logic   i_push,
  input  entry_t i_push_data,
  input  logic   i_pop,
  output entry_t o_head,
  output logic   o_empty,
  output logic   o_full
);

  localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  entry_t            mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]  r_wr_ptr;
  logic [PTR_W-1:0]  r_rd_ptr;
  logic [CNT_W-1:0]  r_count;
  logic              w_push;
  logic              w_pop;

  assign o_empty = (r_count == '0);
  assign o_full  = (r_count == CNT_W'(QUEUE_DEPTH));
  assign w_push  = i_push & ~o_full;   // Drop pushes into a full queue
  assign w_pop   = i_pop & ~o_empty;
  assign o_head  = mem[r_rd_ptr];      // Head always visible

  always_ff @(posedge axi_clk)
  begin
    if (w_push)
    begin
      mem[r_wr_ptr] <= i_push_data;
    end
  end

  always_ff @(posedge axi_clk or negedge cal_done)
  begin
    if (!cal_done)
    begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end
    else
    begin
      if (w_push)
      begin
        r_wr_ptr <= (r_wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : r_wr_ptr + 1'b1;
      end
      if (w_pop)
      begin
        r_rd_ptr <= (r_rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : r_rd_ptr + 1'b1;
      end
      if (w_push && !w_pop)
      begin
        r_count <= r_count + 1'b1;
      end
      else if (w_pop && !w_push)
      begin
        r_count <= r_count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* ddr_axi_cmd_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module ddr_axi_cmd_decode
  import ddr_axi_pkg::*;
#(
  parameter int QUEUE_DEPTH = 32
) (
  input  logic              axi_clk,
  input  logic              cal_done,
  input  logic [ADDR_W-1:0] i_aaddr,
  input  logic              i_atype,
  input  logic              i_avalid,
  input  logic [7:0]        i_aid,
  input  logic [7:0]        i_alen,
  input  logic [1:0]        i_aburst,
  input  logic              i_wr_busy,
  input  logic              i_rd_busy,
  input  logic              i_wr_pop,
  input  logic              i_rd_pop,
  output logic              o_aready,
  output axi_cmd_t          o_wr_cmd,
  output logic              o_wr_cmd_valid,
  output axi_cmd_t          o_rd_cmd,
  output logic              o_rd_cmd_valid,
  output logic              o_wr_accept,
  output logic              o_rd_accept,
  output axi_cmd_t          o_accept_cmd
);

  logic w_wr_full;
  logic w_rd_full;
  logic w_wr_empty;
  logic w_rd_empty;
  logic w_accept;
  logic r_run;  // Set one cycle after reset release

  always_ff @(posedge axi_clk or negedge cal_done)
  begin
    if (!cal_done)
    begin
      r_run <= 1'b0;
    end
    else
    begin
      r_run <= 1'b1;
    end
  end

  // Both queues must have room and the controller must be free
  assign o_aready = r_run & ~w_wr_full & ~w_rd_full & ~i_wr_busy & ~i_rd_busy;
  assign w_accept = i_avalid & o_aready;

  assign o_accept_cmd.word_addr = {{WORD_SHIFT{1'b0}}, i_aaddr[ADDR_W-1:WORD_SHIFT]};
  assign o_accept_cmd.len       = i_alen;
  assign o_accept_cmd.burst     = i_aburst;
  assign o_accept_cmd.id        = i_aid;

  assign o_wr_accept    = w_accept & i_atype;   // Type high selects write
  assign o_rd_accept    = w_accept & ~i_atype;
  assign o_wr_cmd_valid = ~w_wr_empty;
  assign o_rd_cmd_valid = ~w_rd_empty;

  ddr_axi_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .entry_t     (axi_cmd_t)
  ) wr_cmd_queue_inst (
    .axi_clk     (axi_clk),
    .cal_done    (cal_done),
    .i_push      (o_wr_accept),
    .i_push_data (o_accept_cmd),
    .i_pop       (i_wr_pop),
    .o_head      (o_wr_cmd),
    .o_empty     (w_wr_empty),
    .o_full      (w_wr_full)
  );

  ddr_axi_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .entry_t     (axi_cmd_t)
  ) rd_cmd_queue_inst (
    .axi_clk     (axi_clk),
    .cal_done    (cal_done),
    .i_push      (o_rd_accept),
    .i_push_data (o_accept_cmd),
    .i_pop       (i_rd_pop),
    .o_head      (o_rd_cmd),
    .o_empty     (w_rd_empty),
    .o_full      (w_rd_full)
  );

endmodule

`default_nettype wire

/* ddr_axi_wr_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module ddr_axi_wr_exec
  import ddr_axi_pkg::*;
(
  input  logic              axi_clk,
  input  logic              cal_done,
  input  axi_cmd_t          i_cmd,
  input  logic              i_cmd_valid,
  input  logic [DATA_W-1:0] i_wdata,
  input  logic [MASK_W-1:0] i_strb,
  input  logic              i_wvalid,
  input  logic              i_wlast,
  input  logic              i_wr_busy,
  output logic              o_wready,
  output logic              o_cmd_pop,
  output native_wr_t        o_wr,
  output logic              o_wr_en
);

  logic              r_active;  // Burst loaded, taking beats
  logic [ADDR_W-1:0] r_addr;
  logic [1:0]        r_burst;
  logic              w_beat;

  assign o_wready  = r_active & ~i_wr_busy;
  assign w_beat    = i_wvalid & o_wready;
  assign o_cmd_pop = w_beat & i_wlast;  // Last beat retires the command

  always_ff @(posedge axi_clk or negedge cal_done)
  begin
    if (!cal_done)
    begin
      r_active <= 1'b0;
      r_addr   <= '0;
      r_burst  <= '0;
      o_wr_en  <= 1'b0;
    end
    else
    begin
      o_wr_en <= w_beat;
      if (!r_active && i_cmd_valid)
      begin
        r_active <= 1'b1;  // Load head command
        r_addr   <= i_cmd.word_addr;
        r_burst  <= i_cmd.burst;
      end
      else if (w_beat)
      begin
        if (r_burst == BURST_INCR)
        begin
          r_addr <= r_addr + 1'b1;
        end
        if (i_wlast)
        begin
          r_active <= 1'b0;
        end
      end
    end
  end

  // Native write payload, one cycle behind the beat
  always_ff @(posedge axi_clk)
  begin
    if (w_beat)
    begin
      o_wr.addr <= r_addr;
      o_wr.data <= i_wdata;
      o_wr.mask <= ~i_strb;  // Strobe low means masked byte
    end
  end

endmodule

`default_nettype wire

/* ddr_axi_rd_exec.sv */
`timescale 1ns/100ps
`default_nettype none

module ddr_axi_rd_exec
  import ddr_axi_pkg::*;
(
  input  logic              axi_clk,
  input  logic              cal_done,
  input  axi_cmd_t          i_cmd,
  input  logic              i_cmd_valid,
  input  logic              i_rd_busy,
  output logic              o_cmd_pop,
  output logic [ADDR_W-1:0] o_rd_addr,
  output logic              o_rd_addr_en
);

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_LOAD,
    RD_ISSUE
  } rd_state_t;

  rd_state_t  r_state;
  logic [7:0] r_remain;  // Beats left after the current one
  logic [1:0] r_burst;
  logic       w_issue;

  // One address per cycle that the controller is free
  assign w_issue      = (r_state == RD_ISSUE) & ~i_rd_busy;
  assign o_rd_addr_en = w_issue;
  assign o_cmd_pop    = w_issue & (r_remain == 8'd0);

  always_ff @(posedge axi_clk or negedge cal_done)
  begin
    if (!cal_done)
    begin
      r_state   <= RD_IDLE;
      r_remain  <= '0;
      r_burst   <= '0;
      o_rd_addr <= '0;
    end
    else
    begin
      case (r_state)
        RD_IDLE:
        begin
          if (i_cmd_valid)
          begin
            r_state <= RD_LOAD;
          end
        end
        RD_LOAD:
        begin
          o_rd_addr <= i_cmd.word_addr;
          r_remain  <= i_cmd.len;
          r_burst   <= i_cmd.burst;
          r_state   <= RD_ISSUE;
        end
        RD_ISSUE:
        begin
          if (w_issue)
          begin
            if (r_burst == BURST_INCR)
            begin
              o_rd_addr <= o_rd_addr + 1'b1;
            end
            if (r_remain == 8'd0)
            begin
              r_state <= RD_IDLE;  // Head popped this cycle
            end
            else
            begin
              r_remain <= r_remain - 1'b1;
            end
          end
        end
        default:
        begin
          r_state <= RD_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* ddr_axi_result.sv */
`timescale 1ns/100ps
`default_nettype none

module ddr_axi_result
  import ddr_axi_pkg::*;
#(
  parameter int QUEUE_DEPTH = 32
) (
  input  logic              axi_clk,
  input  logic              cal_done,
  input  logic              i_wr_accept,
  input  logic              i_rd_accept,
  input  axi_cmd_t          i_accept_cmd,
  input  logic              i_wr_ack,
  input  logic              i_bready,
  output logic              o_bvalid,
  output logic [7:0]        o_bid,
  output logic [1:0]        o_bresp,
  input  logic              i_rd_valid,
  input  logic [DATA_W-1:0] i_rd_data,
  input  logic              i_rready,
  output logic              o_rvalid,
  output logic [DATA_W-1:0] o_rdata,
  output logic              o_rlast,
  output logic [7:0]        o_rid,
  output logic [1:0]        o_rresp,
  output logic              o_rd_en
);

  axi_cmd_t   w_wr_head;   // Oldest write still waiting for acks
  logic       w_resp_empty;
  logic       w_wr_done;
  logic       w_rd_done;
  logic [7:0] w_rlen;
  logic [7:0] r_ack_cnt;
  logic [7:0] r_beat_cnt;

  // Last ack of the head burst
  assign w_wr_done = i_wr_ack & (r_ack_cnt == w_wr_head.len);
  assign o_bvalid  = ~w_resp_empty;
  assign o_bresp   = 2'b00;

  // Read data passes straight from the controller
  assign o_rvalid  = i_rd_valid;
  assign o_rdata   = i_rd_data;
  assign o_rd_en   = i_rready;
  assign o_rresp   = 2'b00;
  assign o_rlast   = o_rvalid & (r_beat_cnt == w_rlen);
  assign w_rd_done = o_rlast & o_rvalid & i_rready;

  always_ff @(posedge axi_clk or negedge cal_done)
  begin
    if (!cal_done)
    begin
      r_ack_cnt  <= '0;
      r_beat_cnt <= '0;
    end
    else
    begin
      if (w_wr_done)
      begin
        r_ack_cnt <= '0;
      end
      else if (i_wr_ack)
      begin
        r_ack_cnt <= r_ack_cnt + 1'b1;
      end
      if (w_rd_done)
      begin
        r_beat_cnt <= '0;
      end
      else if (o_rvalid && i_rready)
      begin
        r_beat_cnt <= r_beat_cnt + 1'b1;
      end
    end
  end

  ddr_axi_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .entry_t     (axi_cmd_t)
  ) wr_len_queue_inst (
    .axi_clk     (axi_clk),
    .cal_done    (cal_done),
    .i_push      (i_wr_accept),
    .i_push_data (i_accept_cmd),
    .i_pop       (w_wr_done),
    .o_head      (w_wr_head),
    .o_empty     (),
    .o_full      ()
  );

  ddr_axi_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .entry_t     (logic [7:0])
  ) resp_queue_inst (
    .axi_clk     (axi_clk),
    .cal_done    (cal_done),
    .i_push      (w_wr_done),
    .i_push_data (w_wr_head.id),
    .i_pop       (o_bvalid & i_bready),
    .o_head      (o_bid),
    .o_empty     (w_resp_empty),
    .o_full      ()
  );

  ddr_axi_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .entry_t     (logic [7:0])
  ) rd_len_queue_inst (
    .axi_clk     (axi_clk),
    .cal_done    (cal_done),
    .i_push      (i_rd_accept),
    .i_push_data (i_accept_cmd.len),
    .i_pop       (w_rd_done),
    .o_head      (w_rlen),
    .o_empty     (),
    .o_full      ()
  );

  ddr_axi_queue #(
    .QUEUE_DEPTH (QUEUE_DEPTH),
    .entry_t     (logic [7:0])
  ) rd_id_queue_inst (
    .axi_clk     (axi_clk),
    .cal_done    (cal_done),
    .i_push      (i_rd_accept),
    .i_push_data (i_accept_cmd.id),
    .i_pop       (w_rd_done),
    .o_head      (o_rid),
    .o_empty     (),
    .o_full      ()
  );

endmodule

`default_nettype wire

/* ddr_axi_bridge.sv */
`timescale 1ns/100ps
`default_nettype none

module ddr_axi_bridge
  import ddr_axi_pkg::*;
#(
  parameter int QUEUE_DEPTH = 32
) (
  input  logic              axi_clk,
  input  logic              cal_done,
  // Shared address channel
  input  logic [ADDR_W-1:0] i_aaddr,
  input  logic              i_atype,
  input  logic              i_avalid,
  input  logic [7:0]        i_aid,
  input  logic [7:0]        i_alen,
  input  logic [1:0]        i_aburst,
  output logic              o_aready,
  // Write data and response
  input  logic [DATA_W-1:0] i_wdata,
  input  logic [MASK_W-1:0] i_strb,
  input  logic              i_wvalid,
  input  logic              i_wlast,
  output logic              o_wready,
  output logic [7:0]        o_bid,
  output logic [1:0]        o_bresp,
  output logic              o_bvalid,
  input  logic              i_bready,
  // Read data
  output logic [DATA_W-1:0] o_rdata,
  output logic [7:0]        o_rid,
  output logic              o_rlast,
  output logic [1:0]        o_rresp,
  output logic              o_rvalid,
  input  logic              i_rready,
  // Native controller side
  output native_wr_t        o_wr,
  output logic              o_wr_en,
  input  logic              i_wr_ack,
  input  logic              i_wr_busy,
  output logic [ADDR_W-1:0] o_rd_addr,
  output logic              o_rd_addr_en,
  output logic              o_rd_en,
  input  logic [DATA_W-1:0] i_rd_data,
  input  logic              i_rd_valid,
  input  logic              i_rd_busy
);

  axi_cmd_t w_wr_cmd;
  axi_cmd_t w_rd_cmd;
  axi_cmd_t w_accept_cmd;
  logic     w_wr_cmd_valid;
  logic     w_rd_cmd_valid;
  logic     w_wr_pop;
  logic     w_rd_pop;
  logic     w_wr_accept;
  logic     w_rd_accept;

  ddr_axi_cmd_decode #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) cmd_decode_inst (
    .axi_clk        (axi_clk),
    .cal_done       (cal_done),
    .i_aaddr        (i_aaddr),
    .i_atype        (i_atype),
    .i_avalid       (i_avalid),
    .i_aid          (i_aid),
    .i_alen         (i_alen),
    .i_aburst       (i_aburst),
    .i_wr_busy      (i_wr_busy),
    .i_rd_busy      (i_rd_busy),
    .i_wr_pop       (w_wr_pop),
    .i_rd_pop       (w_rd_pop),
    .o_aready       (o_aready),
    .o_wr_cmd       (w_wr_cmd),
    .o_wr_cmd_valid (w_wr_cmd_valid),
    .o_rd_cmd       (w_rd_cmd),
    .o_rd_cmd_valid (w_rd_cmd_valid),
    .o_wr_accept    (w_wr_accept),
    .o_rd_accept    (w_rd_accept),
    .o_accept_cmd   (w_accept_cmd)
  );

  ddr_axi_wr_exec wr_exec_inst (
    .axi_clk     (axi_clk),
    .cal_done    (cal_done),
    .i_cmd       (w_wr_cmd),
    .i_cmd_valid (w_wr_cmd_valid),
    .i_wdata     (i_wdata),
    .i_strb      (i_strb),
    .i_wvalid    (i_wvalid),
    .i_wlast     (i_wlast),
    .i_wr_busy   (i_wr_busy),
    .o_wready    (o_wready),
    .o_cmd_pop   (w_wr_pop),
    .o_wr        (o_wr),
    .o_wr_en     (o_wr_en)
  );

  ddr_axi_rd_exec rd_exec_inst (
    .axi_clk      (axi_clk),
    .cal_done     (cal_done),
    .i_cmd        (w_rd_cmd),
    .i_cmd_valid  (w_rd_cmd_valid),
    .i_rd_busy    (i_rd_busy),
    .o_cmd_pop    (w_rd_pop),
    .o_rd_addr    (o_rd_addr),
    .o_rd_addr_en (o_rd_addr_en)
  );

  ddr_axi_result #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) result_inst (
    .axi_clk      (axi_clk),
    .cal_done     (cal_done),
    .i_wr_accept  (w_wr_accept),
    .i_rd_accept  (w_rd_accept),
    .i_accept_cmd (w_accept_cmd),
    .i_wr_ack     (i_wr_ack),
    .i_bready     (i_bready),
    .o_bvalid     (o_bvalid),
    .o_bid        (o_bid),
    .o_bresp      (o_bresp),
    .i_rd_valid   (i_rd_valid),
    .i_rd_data    (i_rd_data),
    .i_rready     (i_rready),
    .o_rvalid     (o_rvalid),
    .o_rdata      (o_rdata),
    .o_rlast      (o_rlast),
    .o_rid        (o_rid),
    .o_rresp      (o_rresp),
    .o_rd_en      (o_rd_en)
  );

endmodule

`default_nettype wire

/* ddr_axi_bridge_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module ddr_axi_bridge_assertions (
  input wire       axi_clk,
  input wire       cal_done,
  input wire       o_rlast,
  input wire       o_rvalid,
  input wire       o_bvalid,
  input wire       i_bready,
  input wire [7:0] o_bid,
  input wire       o_rd_addr_en,
  input wire       i_rd_busy,
  input wire       o_wr_en
);

  rlast_with_rvalid: assert property (@(posedge axi_clk) disable iff (!cal_done)
    o_rlast |-> o_rvalid)
    else $error("rlast without rvalid");

  // Response must stay put until taken
  bvalid_holds: assert property (@(posedge axi_clk) disable iff (!cal_done)
    (o_bvalid && !i_bready) |=> (o_bvalid && $stable(o_bid)))
    else $error("write response dropped under back-pressure");

  no_addr_when_busy: assert property (@(posedge axi_clk) disable iff (!cal_done)
    o_rd_addr_en |-> !i_rd_busy)
    else $error("read address issued while controller busy");

  wr_en_quiet_in_reset: assert property (@(posedge axi_clk)
    !cal_done |-> !o_wr_en)
    else $error("native write during reset");

endmodule

bind ddr_axi_bridge ddr_axi_bridge_assertions assertions_inst (.*);

`default_nettype wire

/* ddr_axi_bridge_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ddr_axi_bridge_tb
  import ddr_axi_pkg::*;
;

  localparam int QUEUE_DEPTH = 32;
  localparam int MAX_TX      = 64;
  localparam int WAIT_LIMIT  = 2000;  // Cycles allowed for any single wait

  logic              axi_clk;
  logic              cal_done;
  logic [ADDR_W-1:0] i_aaddr;
  logic              i_atype;
  logic              i_avalid;
  logic [7:0]        i_aid;
  logic [7:0]        i_alen;
  logic [1:0]        i_aburst;
  logic              o_aready;
  logic [DATA_W-1:0] i_wdata;
  logic [MASK_W-1:0] i_strb;
  logic              i_wvalid;
  logic              i_wlast;
  logic              o_wready;
  logic [7:0]        o_bid;
  logic [1:0]        o_bresp;
  logic              o_bvalid;
  logic              i_bready;
  logic [DATA_W-1:0] o_rdata;
  logic [7:0]        o_rid;
  logic              o_rlast;
  logic [1:0]        o_rresp;
  logic              o_rvalid;
  logic              i_rready;
  native_wr_t        o_wr;
  logic              o_wr_en;
  logic              i_wr_ack;
  logic              i_wr_busy;
  logic [ADDR_W-1:0] o_rd_addr;
  logic              o_rd_addr_en;
  logic              o_rd_en;
  logic [DATA_W-1:0] i_rd_data;
  logic              i_rd_valid;
  logic              i_rd_busy;

  // Transactions from the stimulus file
  int                n_tx;
  logic              t_write [MAX_TX];
  logic [7:0]        t_id    [MAX_TX];
  logic [ADDR_W-1:0] t_addr  [MAX_TX];
  logic [7:0]        t_len   [MAX_TX];
  logic [1:0]        t_burst [MAX_TX];
  logic [DATA_W-1:0] t_seed  [MAX_TX];

  // What the native side and the AXI side were seen doing
  native_wr_t        wr_log [$];
  logic [ADDR_W-1:0] rd_addr_log [$];
  logic [DATA_W-1:0] rdata_log [$];
  logic              rlast_log [$];
  logic [7:0]        rid_log [$];
  logic [1:0]        rresp_log [$];
  logic              rd_en_log [$];
  logic [7:0]        bid_log [$];
  logic [1:0]        bresp_log [$];
  int                resp_acks [$];   // Acks already given when each response was seen

  logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];      // Native memory model
  logic [DATA_W-1:0] exp_mem [logic [ADDR_W-1:0]];  // Expected contents
  logic [1:0]        ack_pipe;
  logic [2:0]        rdv_pipe;
  logic [ADDR_W-1:0] rda_pipe [3];
  int                ack_total;
  logic              busy_rand;
  int                errors;
  int                tests_run;
  int                tests_failed;

  ddr_axi_bridge #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) ddr_axi_bridge_inst (
    .*
  );

  always #20 axi_clk = ~axi_clk;  // 40 ns period

  // Controller model
  // Registered outputs are taken first, then the next inputs are driven,
  // and the outputs that follow those inputs are taken once they settle
  always @(negedge axi_clk)
  begin
    if (cal_done)
    begin
      if (o_wr_en)
      begin
        mem[o_wr.addr] = o_wr.data;
        wr_log.push_back(o_wr);
      end
      i_wr_ack = ack_pipe[1];  // Ack two cycles after the write
      if (ack_pipe[1])
      begin
        ack_total++;
      end
      ack_pipe = {ack_pipe[0], o_wr_en};
      i_rd_valid = rdv_pipe[2];  // Data three cycles after the address
      if (rdv_pipe[2] && mem.exists(rda_pipe[2]))
      begin
        i_rd_data = mem[rda_pipe[2]];
      end
      else
      begin
        i_rd_data = '0;
      end
      i_rd_busy = busy_rand ? (($urandom % 3) == 0) : 1'b0;
      i_bready  = ~i_bready;  // Every other cycle holds the response back
      #1;
      if (o_bvalid && i_bready)
      begin
        bid_log.push_back(o_bid);
        bresp_log.push_back(o_bresp);
        resp_acks.push_back(ack_total);
      end
      if (o_rvalid && i_rready)
      begin
        rdata_log.push_back(o_rdata);
        rlast_log.push_back(o_rlast);
        rid_log.push_back(o_rid);
        rresp_log.push_back(o_rresp);
        rd_en_log.push_back(o_rd_en);
      end
      if (o_rd_addr_en)
      begin
        rd_addr_log.push_back(o_rd_addr);
      end
      rdv_pipe    = {rdv_pipe[1:0], o_rd_addr_en};
      rda_pipe[2] = rda_pipe[1];
      rda_pipe[1] = rda_pipe[0];
      rda_pipe[0] = o_rd_addr;
    end
  end

  task automatic give_up(input string what);
    $display("Timeout while waiting for %0s", what);
    $display("Simulation FAILED");
    $finish;
  endtask

  task automatic show_mismatch(input string name, input string field,
                               input logic [DATA_W-1:0] exp, input logic [DATA_W-1:0] act);
    $display("[FAIL] %0s %0s expected %0h actual %0h", name, field, exp, act);
    errors++;
  endtask

  task automatic load_stimulus();
    int    fd;
    int    cnt;
    string line;
    fd   = $fopen("ddr_axi_stimulus.txt", "r");
    n_tx = 0;
    if (fd == 0)
    begin
      $display("Could not open the stimulus file");
      errors++;
      return;
    end
    while (!$feof(fd) && n_tx < MAX_TX)
    begin
      cnt = $fgets(line, fd);
      if (cnt > 0 && line[0] != "#")
      begin
        cnt = $sscanf(line, "%h %h %h %h %h %h", t_write[n_tx], t_id[n_tx],
                      t_addr[n_tx], t_len[n_tx], t_burst[n_tx], t_seed[n_tx]);
        if (cnt == 6)
        begin
          n_tx++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic send_cmd(input int k);
    int cnt;
    @(negedge axi_clk);
    i_aaddr  = t_addr[k];
    i_atype  = t_write[k];
    i_aid    = t_id[k];
    i_alen   = t_len[k];
    i_aburst = t_burst[k];
    i_avalid = 1'b1;
    #1;
    cnt = 0;
    while (!o_aready)
    begin
      @(negedge axi_clk);
      #1;
      cnt++;
      if (cnt > WAIT_LIMIT)
      begin
        give_up("o_aready");
      end
    end
    @(negedge axi_clk);
    i_avalid = 1'b0;
  endtask

  task automatic run_write(input int k, inout int beats_done, inout int writes_done);
    int          cnt;
    int          base;
    int          start_err;
    string       name;
    native_wr_t  got;
    logic [ADDR_W-1:0] exp_addr;
    name      = $sformatf("write_id%02h", t_id[k]);
    start_err = errors;
    base      = wr_log.size();
    send_cmd(k);
    for (int b = 0; b <= int'(t_len[k]); b++)
    begin
      @(negedge axi_clk);
      i_wdata  = t_seed[k] + DATA_W'(b);
      i_strb   = t_seed[k][MASK_W-1:0];
      i_wvalid = 1'b1;
      i_wlast  = (b == int'(t_len[k]));
      #1;
      cnt = 0;
      while (!o_wready)
      begin
        @(negedge axi_clk);
        #1;
        cnt++;
        if (cnt > WAIT_LIMIT)
        begin
          give_up("o_wready");
        end
      end
    end
    @(negedge axi_clk);
    i_wvalid = 1'b0;
    i_wlast  = 1'b0;
    writes_done++;
    beats_done += int'(t_len[k]) + 1;
    cnt = 0;
    while (bid_log.size() < writes_done)
    begin
      @(negedge axi_clk);
      cnt++;
      if (cnt > WAIT_LIMIT)
      begin
        give_up("o_bvalid");
      end
    end
    for (int b = 0; b <= int'(t_len[k]); b++)
    begin
      exp_addr = (t_addr[k] >> WORD_SHIFT) + ((t_burst[k] == 2'b01) ? ADDR_W'(b) : '0);
      got      = wr_log[base + b];
      if (got.addr != exp_addr)
        show_mismatch(name, "addr", DATA_W'(exp_addr), DATA_W'(got.addr));
      if (got.data != t_seed[k] + DATA_W'(b))
        show_mismatch(name, "data", t_seed[k] + DATA_W'(b), got.data);
      if (got.mask != ~t_seed[k][MASK_W-1:0])
        show_mismatch(name, "mask", DATA_W'(~t_seed[k][MASK_W-1:0]), DATA_W'(got.mask));
      exp_mem[exp_addr] = t_seed[k] + DATA_W'(b);
    end
    if (bid_log[writes_done - 1] != t_id[k])
      show_mismatch(name, "bid", DATA_W'(t_id[k]), DATA_W'(bid_log[writes_done - 1]));
    if (bresp_log[writes_done - 1] != 2'b00)
      show_mismatch(name, "bresp", '0, DATA_W'(bresp_log[writes_done - 1]));
    if (resp_acks[writes_done - 1] < beats_done)
    begin
      $display("%0s got its response before all beats were acknowledged", name);
      errors++;
    end
    tests_run++;
    if (errors != start_err)
      tests_failed++;
    $display("Test %0s done with %0d errors", name, errors - start_err);
  endtask

  task automatic run_reads(input int first, input int last, inout int rd_beats);
    int                cnt;
    int                idx;
    int                start_err;
    string             name;
    logic [ADDR_W-1:0] exp_addr;
    logic [DATA_W-1:0] exp_data;
    busy_rand = 1'b1;
    for (int j = first; j <= last; j++)
    begin
      send_cmd(j);  // Commands go in back to back
    end
    idx = rd_beats;
    for (int j = first; j <= last; j++)
    begin
      rd_beats += int'(t_len[j]) + 1;
    end
    cnt = 0;
    while (rdata_log.size() < rd_beats)
    begin
      @(negedge axi_clk);
      cnt++;
      if (cnt > WAIT_LIMIT)
      begin
        give_up("read data");
      end
    end
    busy_rand = 1'b0;
    for (int j = first; j <= last; j++)
    begin
      name      = $sformatf("read_id%02h", t_id[j]);
      start_err = errors;
      for (int b = 0; b <= int'(t_len[j]); b++)
      begin
        exp_addr = (t_addr[j] >> WORD_SHIFT) + ((t_burst[j] == 2'b01) ? ADDR_W'(b) : '0);
        exp_data = exp_mem.exists(exp_addr) ? exp_mem[exp_addr] : '0;
        if (rd_addr_log[idx] != exp_addr)
          show_mismatch(name, "rd_addr", DATA_W'(exp_addr), DATA_W'(rd_addr_log[idx]));
        if (rdata_log[idx] != exp_data)
          show_mismatch(name, "rdata", exp_data, rdata_log[idx]);
        if (rlast_log[idx] != (b == int'(t_len[j])))
          show_mismatch(name, "rlast", DATA_W'(b == int'(t_len[j])), DATA_W'(rlast_log[idx]));
        if (rid_log[idx] != t_id[j])
          show_mismatch(name, "rid", DATA_W'(t_id[j]), DATA_W'(rid_log[idx]));
        if (rresp_log[idx] != 2'b00)
          show_mismatch(name, "rresp", '0, DATA_W'(rresp_log[idx]));
        if (rd_en_log[idx] != 1'b1)  // Follows i_rready, held high
          show_mismatch(name, "rd_en", DATA_W'(1), DATA_W'(rd_en_log[idx]));
        idx++;
      end
      tests_run++;
      if (errors != start_err)
        tests_failed++;
      $display("Test %0s done with %0d errors", name, errors - start_err);
    end
  endtask

  initial
  begin
    int k;
    int last;
    int beats_done;
    int writes_done;
    int rd_beats;
    axi_clk = 1'b0;
    cal_done = 1'b0;
    i_aaddr = '0;
    i_atype = 1'b0;
    i_avalid = 1'b0;
    i_aid = '0;
    i_alen = '0;
    i_aburst = '0;
    i_wdata = '0;
    i_strb = '0;
    i_wvalid = 1'b0;
    i_wlast = 1'b0;
    i_bready = 1'b1;
    i_rready = 1'b1;
    i_wr_ack = 1'b0;
    i_wr_busy = 1'b0;
    i_rd_data = '0;
    i_rd_valid = 1'b0;
    i_rd_busy = 1'b0;
    ack_pipe = '0;
    rdv_pipe = '0;
    rda_pipe = '{default: '0};
    ack_total = 0;
    busy_rand = 1'b0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    beats_done = 0;
    writes_done = 0;
    rd_beats = 0;
    void'($urandom(32'h49ff));
    load_stimulus();
    repeat (3) @(negedge axi_clk);
    cal_done = 1'b1;
    k = 0;
    while (k < n_tx)
    begin
      if (t_write[k])
      begin
        run_write(k, beats_done, writes_done);
        k++;
      end
      else
      begin
        last = k;
        while (last + 1 < n_tx && !t_write[last + 1])
          last++;
        run_reads(k, last, rd_beats);
        k = last + 1;
      end
    end
    repeat (20) @(negedge axi_clk);  // Let any stray response or beat show up
    if (bid_log.size() != writes_done)
      show_mismatch("summary", "response count", DATA_W'(writes_done), DATA_W'(bid_log.size()));
    if (wr_log.size() != beats_done)
      show_mismatch("summary", "native write count", DATA_W'(beats_done),
                    DATA_W'(wr_log.size()));
    if (rd_addr_log.size() != rd_beats)
      show_mismatch("summary", "read address count", DATA_W'(rd_beats),
                    DATA_W'(rd_addr_log.size()));
    if (rdata_log.size() != rd_beats)
      show_mismatch("summary", "read beat count", DATA_W'(rd_beats), DATA_W'(rdata_log.size()));
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_run > 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ddr_axi_stimulus.txt */
# columns (hex): type (1 write, 0 read) id byte_addr len burst data_seed
# write data per beat is seed plus beat index, strobe is the seed's low 16 bits
1 11 00001000 3 1 a5a50000
1 12 00002040 0 1 0000ffff
1 13 00003000 2 0 1234f0f0
1 14 00004000 7 1 cafe0000
1 15 00005010 1 1 5555aaaa
0 21 00001000 3 1 0
0 22 00004000 7 1 0
0 23 00002040 0 1 0
0 24 00003000 0 1 0
0 25 00005010 1 1 0

/* compile.f */
ddr_axi_pkg.sv
ddr_axi_queue.sv
ddr_axi_cmd_decode.sv
ddr_axi_wr_exec.sv
ddr_axi_rd_exec.sv
ddr_axi_result.sv
ddr_axi_bridge.sv
ddr_axi_bridge_assertions.sv
ddr_axi_bridge_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= ddr_axi_bridge_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Simulation PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
